//--- include/align_config.svh
`ifndef ALIGN_CONFIG_SVH
`define ALIGN_CONFIG_SVH

// Fetch address width, byte addressed
`define ALIGN_ADDR_W 32

// Width of one fetched word
`define ALIGN_DATA_W 32

// Width of one halfword, the granule of compressed instructions
`define ALIGN_HALF_W 16

// Entries in the response queue
// Three words cover a straddling instruction plus one word in flight
`define ALIGN_DEPTH 3

// Requests that may be in flight towards the memory at once
`define ALIGN_MAX_OUTSTANDING 2

// Low bits of a halfword that mark a full 32-bit instruction
`define ALIGN_UNCOMP_LSB 2'b11

`endif

//--- source/align_pkg.sv
`include "align_config.svh"

package align_pkg;

  //////////////////////////////////////////////////////////////////////
  // Response word
  //////////////////////////////////////////////////////////////////////

  // One fetched word with its bus error flag
  typedef struct packed {
    logic [`ALIGN_DATA_W-1:0] rdata;
    logic                     err;
  } resp_word_t;

  //////////////////////////////////////////////////////////////////////
  // Counters
  //////////////////////////////////////////////////////////////////////

  // Requests in flight, or stale responses still to drop
  typedef logic [1:0] outst_cnt_t;

  // Complete instructions held in the buffer, at most six
  typedef logic [2:0] insn_cnt_t;

  // Complete instructions ending in one incoming word, 0 to 2
  typedef logic [1:0] insn_delta_t;

  // True when a halfword starts a 16-bit instruction
  function automatic logic is_compressed(input logic [1:0] lsb);
    return lsb != `ALIGN_UNCOMP_LSB;
  endfunction

endpackage

//--- source/fetch_req_ctrl.sv
`timescale 1ns/1ps
`include "align_config.svh"

module fetch_req_ctrl (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     prefetch_en_i,
  input  logic                     branch_i,
  input  logic [`ALIGN_ADDR_W-1:0] branch_addr_i,
  input  logic                     kill_i,
  input  logic                     fetch_ready_i,
  input  logic                     resp_valid_i,
  input  align_pkg::insn_cnt_t     insn_cnt_i,
  output logic                     fetch_valid_o,
  output logic [`ALIGN_ADDR_W-1:0] fetch_addr_o,
  output logic                     busy_o,
  output logic                     resp_accept_o
);

  import align_pkg::*;

  outst_cnt_t               outst_q;
  outst_cnt_t               discard_q;
  outst_cnt_t               discard_branch;
  logic                     req_accepted;
  logic [`ALIGN_ADDR_W-1:0] word_addr_q;
  logic [`ALIGN_ADDR_W-1:0] target_word;

  // Branch target rounded down to its word
  assign target_word = {branch_addr_i[`ALIGN_ADDR_W-1:2], 2'b00};

  // Ask for a word when the buffer runs dry, or on a redirect
  assign fetch_valid_o = prefetch_en_i &&
                         (outst_q < outst_cnt_t'(`ALIGN_MAX_OUTSTANDING)) &&
                         ((insn_cnt_i == '0) ||
                          (insn_cnt_i == insn_cnt_t'(1) && outst_q == '0) ||
                          branch_i);

  assign fetch_addr_o = branch_i ? target_word : word_addr_q;
  assign req_accepted = fetch_valid_o && fetch_ready_i;

  assign busy_o = (outst_q != '0) || fetch_valid_o;

  // Responses in the branch cycle belong to the old path
  assign resp_accept_o = resp_valid_i && (discard_q == '0) && !branch_i;

  // Old-path words still to come once this cycle is over
  // A word arriving now is dropped, so it leaves the count
  always_comb begin
    discard_branch = outst_q;
    if (resp_valid_i && (kill_i || branch_i)) begin
      discard_branch = outst_q - outst_cnt_t'(1);
    end
  end

  ////////////////////////////////////////////////////////////////////////
  // Counters and running address
  ////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outst_q     <= '0;
      discard_q   <= '0;
      word_addr_q <= '0;
    end else begin
      // In flight count, one up per request, one down per response
      case ({req_accepted, resp_valid_i})
        2'b10:   outst_q <= outst_q + outst_cnt_t'(1);
        2'b01:   outst_q <= outst_q - outst_cnt_t'(1);
        default: outst_q <= outst_q;
      endcase

      if (branch_i) begin
        discard_q <= discard_branch;
      end else if (resp_valid_i && (discard_q != '0)) begin
        discard_q <= discard_q - outst_cnt_t'(1);
      end

      // Next word to ask for
      if (branch_i) begin
        word_addr_q <= req_accepted ? target_word + `ALIGN_ADDR_W'(4) : target_word;
      end else if (req_accepted) begin
        word_addr_q <= word_addr_q + `ALIGN_ADDR_W'(4);
      end
    end
  end

endmodule

//--- source/insn_boundary_tracker.sv
`timescale 1ns/1ps
`include "align_config.svh"

module insn_boundary_tracker (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   branch_i,
  input  logic                   branch_half_i,
  input  logic                   kill_i,
  input  logic                   resp_accept_i,
  input  align_pkg::resp_word_t  resp_i,
  input  logic                   pop_i,
  output align_pkg::insn_cnt_t   insn_cnt_o
);

  import align_pkg::*;

  localparam int H = `ALIGN_HALF_W;

  logic        aligned_q;
  logic        complete_q;
  logic        aligned_n;
  logic        complete_n;
  logic        lo_comp;
  logic        hi_comp;
  insn_delta_t n_incoming;
  insn_cnt_t   cnt_q;

  // Halfword kinds of the incoming word
  assign lo_comp = is_compressed(resp_i.rdata[1:0]);
  assign hi_comp = is_compressed(resp_i.rdata[H+1:H]);

  ////////////////////////////////////////////////////////////////////////
  // Boundary flags
  ////////////////////////////////////////////////////////////////////////

  // aligned=0 with complete=1 only follows a halfword branch
  // Then the lower half of the first word is skipped
  always_comb begin
    aligned_n  = aligned_q;
    complete_n = complete_q;
    n_incoming = insn_delta_t'(0);
    if (branch_i) begin
      aligned_n  = !branch_half_i;
      complete_n = branch_half_i;
    end else if (resp_accept_i) begin
      if (aligned_q && !lo_comp) begin
        // Whole 32-bit instruction, flags unchanged
        n_incoming = insn_delta_t'(1);
      end else if (aligned_q || !complete_q) begin
        // Lower half ends an instruction, the upper half decides the rest
        n_incoming = hi_comp ? insn_delta_t'(2) : insn_delta_t'(1);
        aligned_n  = hi_comp;
        complete_n = hi_comp;
      end else begin
        // Halfword target, lower half skipped
        n_incoming = hi_comp ? insn_delta_t'(1) : insn_delta_t'(0);
        aligned_n  = hi_comp;
        complete_n = hi_comp;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // Start of the reset path is word aligned
      aligned_q  <= 1'b1;
      complete_q <= 1'b1;
      cnt_q      <= '0;
    end else begin
      aligned_q  <= aligned_n;
      complete_q <= complete_n;
      // Redirect or kill throws away what is buffered
      if (branch_i || kill_i) begin
        cnt_q <= '0;
      end else begin
        cnt_q <= cnt_q + insn_cnt_t'(n_incoming) - insn_cnt_t'(pop_i);
      end
    end
  end

  assign insn_cnt_o = cnt_q;

endmodule

//--- source/resp_queue.sv
`timescale 1ns/1ps
`include "align_config.svh"

module resp_queue (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  kill_i,
  input  logic                  push_i,
  input  align_pkg::resp_word_t push_data_i,
  input  logic                  shift_i,
  output align_pkg::resp_word_t entry0_o,
  output align_pkg::resp_word_t entry1_o,
  output logic                  valid0_o,
  output logic                  valid1_o
);

  import align_pkg::*;

  localparam int D = `ALIGN_DEPTH;

  // Entry 0 is the oldest word
  resp_word_t       data_q   [D];
  resp_word_t       data_int [D];
  logic [D-1:0]     valid_q;
  logic [D-1:0]     valid_int;
  logic             placed;

  // Fill the first free slot with the incoming word
  always_comb begin
    data_int  = data_q;
    valid_int = valid_q;
    placed    = 1'b0;
    if (push_i) begin
      for (int i = 0; i < D; i++) begin
        if (!valid_q[i] && !placed) begin
          data_int[i]  = push_data_i;
          valid_int[i] = 1'b1;
          placed       = 1'b1;
        end
      end
    end
  end

  // Payload moves down one entry when the front word is used up
  always_ff @(posedge clk) begin
    for (int i = 0; i < D - 1; i++) begin
      data_q[i] <= shift_i ? data_int[i + 1] : data_int[i];
    end
    // Top entry keeps its word and only its valid bit drops on a shift
    data_q[D-1] <= data_int[D-1];
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else if (kill_i) begin
      valid_q <= '0;
    end else if (shift_i) begin
      // Front word used up and dropped
      valid_q <= valid_int >> 1;
    end else begin
      valid_q <= valid_int;
    end
  end

  assign entry0_o = data_q[0];
  assign entry1_o = data_q[1];
  assign valid0_o = valid_q[0];
  assign valid1_o = valid_q[1];

endmodule

//--- source/insn_extract.sv
`timescale 1ns/1ps
`include "align_config.svh"

module insn_extract (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     branch_i,
  input  logic [`ALIGN_ADDR_W-1:0] branch_addr_i,
  input  logic                     kill_i,
  input  logic                     instr_ready_i,
  input  align_pkg::resp_word_t    entry0_i,
  input  align_pkg::resp_word_t    entry1_i,
  input  logic                     valid0_i,
  input  logic                     valid1_i,
  input  logic                     resp_accept_i,
  input  align_pkg::resp_word_t    resp_i,
  output logic                     instr_valid_o,
  output align_pkg::resp_word_t    instr_o,
  output logic [`ALIGN_ADDR_W-1:0] instr_addr_o,
  output logic                     shift_o,
  output logic                     pop_o
);

  import align_pkg::*;

  localparam int H = `ALIGN_HALF_W;
  localparam int A = `ALIGN_ADDR_W;

  resp_word_t front;
  resp_word_t next;
  logic       aligned_comp;
  logic       unaligned_comp;
  logic       any_valid;
  logic       straddle_valid;
  logic       consume;
  logic [A-1:0] addr_q;
  logic [A-1:0] addr_incr;
  logic [A-1:0] addr_n;

  ////////////////////////////////////////////////////////////////////////
  // Source selection
  ////////////////////////////////////////////////////////////////////////

  // Front word, bypassed from the response when the queue is empty
  assign front = valid0_i ? entry0_i : resp_i;
  // Word after the front, queue first, then the response
  assign next  = valid1_i ? entry1_i : resp_i;

  assign aligned_comp   = is_compressed(front.rdata[1:0]);
  assign unaligned_comp = is_compressed(front.rdata[H+1:H]);

  // Something to look at at all
  assign any_valid      = valid0_i || resp_accept_i;
  // Both halves of a straddling instruction present
  assign straddle_valid = valid1_i || (valid0_i && resp_accept_i);

  always_comb begin
    instr_o       = front;
    instr_valid_o = 1'b0;
    if (kill_i) begin
      instr_valid_o = 1'b0;
    end else if (addr_q[1]) begin
      // Upper half of the front word, lower half of the next
      instr_o.rdata = {next.rdata[H-1:0], front.rdata[2*H-1:H]};
      if (unaligned_comp) begin
        instr_o.err   = front.err;
        instr_valid_o = any_valid;
      end else begin
        // Error from either word taints the instruction
        instr_o.err   = front.err | next.err;
        instr_valid_o = straddle_valid;
      end
    end else begin
      instr_valid_o = any_valid;
    end
  end

  ////////////////////////////////////////////////////////////////////////
  // Address advance and queue control
  ////////////////////////////////////////////////////////////////////////

  assign consume   = instr_valid_o && instr_ready_i;
  assign addr_incr = {addr_q[A-1:2], 2'b00} + A'(4);

  always_comb begin
    addr_n = addr_q;
    if (addr_q[1]) begin
      // Next instruction starts in the next word
      addr_n = unaligned_comp ? addr_incr : {addr_incr[A-1:2], 2'b10};
    end else begin
      addr_n = aligned_comp ? {addr_q[A-1:2], 2'b10} : addr_incr;
    end
  end

  // Front word is done after an upper half or a full aligned word
  assign shift_o = consume && (addr_q[1] || !aligned_comp);
  assign pop_o   = consume;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_q <= '0;
    end else if (branch_i) begin
      // Target is the first instruction of the new stream
      addr_q <= branch_addr_i;
    end else if (consume) begin
      addr_q <= addr_n;
    end
  end

  assign instr_addr_o = addr_q;

endmodule

//--- source/align_buffer_top.sv
`timescale 1ns/1ps
`include "align_config.svh"

module align_buffer_top (
  input  logic                     clk,
  input  logic                     rst_n,
  // Control
  input  logic                     prefetch_en_i,
  input  logic                     branch_i,
  input  logic [`ALIGN_ADDR_W-1:0] branch_addr_i,
  input  logic                     kill_i,
  output logic                     busy_o,
  // Fetch requests to memory
  output logic                     fetch_valid_o,
  input  logic                     fetch_ready_i,
  output logic [`ALIGN_ADDR_W-1:0] fetch_addr_o,
  // Memory responses, always accepted
  input  logic                     resp_valid_i,
  input  align_pkg::resp_word_t    resp_i,
  // Decode side
  output logic                     instr_valid_o,
  input  logic                     instr_ready_i,
  output align_pkg::resp_word_t    instr_o,
  output logic [`ALIGN_ADDR_W-1:0] instr_addr_o
);

  import align_pkg::*;

  logic       resp_accept;
  logic       flush;
  logic       shift;
  logic       pop;
  insn_cnt_t  insn_cnt;
  resp_word_t entry0;
  resp_word_t entry1;
  logic       valid0;
  logic       valid1;

  // Queue empties on a redirect as well as on a kill
  assign flush = kill_i | branch_i;

  ////////////////////////////////////////////////////////////////////////
  // Blocks
  ////////////////////////////////////////////////////////////////////////

  fetch_req_ctrl req_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .prefetch_en_i (prefetch_en_i),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .kill_i        (kill_i),
    .fetch_ready_i (fetch_ready_i),
    .resp_valid_i  (resp_valid_i),
    .insn_cnt_i    (insn_cnt),
    .fetch_valid_o (fetch_valid_o),
    .fetch_addr_o  (fetch_addr_o),
    .busy_o        (busy_o),
    .resp_accept_o (resp_accept)
  );

  // Halfword target when bit 1 of the branch address is set
  insn_boundary_tracker trk_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch_i),
    .branch_half_i (branch_addr_i[1]),
    .kill_i        (kill_i),
    .resp_accept_i (resp_accept),
    .resp_i        (resp_i),
    .pop_i         (pop),
    .insn_cnt_o    (insn_cnt)
  );

  resp_queue q_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .kill_i      (flush),
    .push_i      (resp_accept),
    .push_data_i (resp_i),
    .shift_i     (shift),
    .entry0_o    (entry0),
    .entry1_o    (entry1),
    .valid0_o    (valid0),
    .valid1_o    (valid1)
  );

  insn_extract ext_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .kill_i        (kill_i),
    .instr_ready_i (instr_ready_i),
    .entry0_i      (entry0),
    .entry1_i      (entry1),
    .valid0_i      (valid0),
    .valid1_i      (valid1),
    .resp_accept_i (resp_accept),
    .resp_i        (resp_i),
    .instr_valid_o (instr_valid_o),
    .instr_o       (instr_o),
    .instr_addr_o  (instr_addr_o),
    .shift_o       (shift),
    .pop_o         (pop)
  );

endmodule

//--- dv/align_chk.sv
`timescale 1ns/1ps
`include "align_config.svh"

module align_chk (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     fetch_valid_i,
  input  logic                     fetch_ready_i,
  input  logic                     resp_valid_i,
  input  logic                     branch_i,
  input  logic                     kill_i,
  input  logic                     busy_i,
  input  logic                     instr_valid_i,
  input  logic                     instr_ready_i,
  input  align_pkg::resp_word_t    instr_i,
  input  logic [`ALIGN_ADDR_W-1:0] instr_addr_i
);

  import align_pkg::*;

  // Own count of requests in flight, wide enough to show an overrun
  logic [2:0] outst_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outst_q <= '0;
    end else begin
      outst_q <= outst_q + 3'(fetch_valid_i && fetch_ready_i) - 3'(resp_valid_i);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Properties
  //////////////////////////////////////////////////////////////////////

  a_max_outst: assert property (@(posedge clk) disable iff (!rst_n)
    outst_q <= 3'(`ALIGN_MAX_OUTSTANDING))
    else $error("more than two fetch requests outstanding");

  // Held instruction keeps address, low half and error
  // Upper half only matters for a 32-bit instruction
  a_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (instr_valid_i && !instr_ready_i && !branch_i && !kill_i) |=>
    (branch_i || kill_i ||
     (instr_valid_i && $stable(instr_addr_i) && $stable(instr_i.rdata[15:0]) &&
      $stable(instr_i.err) && (instr_i.rdata[1:0] != 2'b11 || $stable(instr_i.rdata)))))
    else $error("decode output changed while stalled");

  a_reset: assert property (@(posedge clk)
    !rst_n |-> (!fetch_valid_i && !instr_valid_i && !busy_i && instr_addr_i == '0))
    else $error("outputs not idle during reset");

endmodule

bind align_buffer_top align_chk chk_i (
  .clk           (clk),
  .rst_n         (rst_n),
  .fetch_valid_i (fetch_valid_o),
  .fetch_ready_i (fetch_ready_i),
  .resp_valid_i  (resp_valid_i),
  .branch_i      (branch_i),
  .kill_i        (kill_i),
  .busy_i        (busy_o),
  .instr_valid_i (instr_valid_o),
  .instr_ready_i (instr_ready_i),
  .instr_i       (instr_o),
  .instr_addr_i  (instr_addr_o)
);

//--- dv/align_tb.sv
`timescale 1ns/1ps
`include "align_config.svh"

module align_tb;

  import align_pkg::*;

  localparam int A         = `ALIGN_ADDR_W;
  localparam int MEM_WORDS = 256;

  logic         clk;
  logic         rst_n;
  logic         prefetch_en;
  logic         branch;
  logic [A-1:0] branch_addr;
  logic         kill;
  logic         busy;
  logic         fetch_valid;
  logic         fetch_ready;
  logic [A-1:0] fetch_addr;
  logic         resp_valid;
  resp_word_t   resp;
  logic         instr_valid;
  logic         instr_ready;
  resp_word_t   instr;
  logic [A-1:0] instr_addr;

  // Memory image and trace contents
  logic [31:0]  mem_data [MEM_WORDS];
  logic         mem_err  [MEM_WORDS];
  logic [7:0]   op_kind  [$];
  logic [A-1:0] op_addr  [$];
  int           op_len   [$];
  logic [A-1:0] exp_addr [$];
  resp_word_t   exp_word [$];

  // Requests waiting for their response, in order
  logic [A-1:0] pend_addr [$];
  int           pend_due  [$];
  logic         acc_pend;
  logic [A-1:0] acc_addr;

  logic [31:0]  lfsr = 32'h54995699;
  int           cyc = 0;
  int           limit = 0;
  int           err_count = 0;
  int           exp_idx = 0;
  int           seg_left = 0;
  string        test_name = "idle";

  align_buffer_top dut_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .prefetch_en_i (prefetch_en),
    .branch_i      (branch),
    .branch_addr_i (branch_addr),
    .kill_i        (kill),
    .busy_o        (busy),
    .fetch_valid_o (fetch_valid),
    .fetch_ready_i (fetch_ready),
    .fetch_addr_o  (fetch_addr),
    .resp_valid_i  (resp_valid),
    .resp_i        (resp),
    .instr_valid_o (instr_valid),
    .instr_ready_i (instr_ready),
    .instr_o       (instr),
    .instr_addr_o  (instr_addr)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Random bits and compare tasks
  //////////////////////////////////////////////////////////////////////

  // Galois LFSR, one step per bit taken
  function automatic logic rand_bit();
    lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
    return lfsr[0];
  endfunction

  task automatic check_addr(input string name, input logic [A-1:0] exp, input logic [A-1:0] act);
    if (act !== exp) begin
      err_count++;
      $display("ERROR %s addr expected %h actual %h", name, exp, act);
    end
  endtask

  // Compressed instructions compare only their low halfword
  task automatic check_instr(input string name, input resp_word_t exp, input resp_word_t act);
    logic [31:0] mask;
    mask = (exp.rdata[1:0] != 2'b11) ? 32'h0000_FFFF : 32'hFFFF_FFFF;
    if ((act.rdata & mask) !== (exp.rdata & mask)) begin
      err_count++;
      $display("ERROR %s instr expected %h actual %h", name, exp.rdata & mask,
               act.rdata & mask);
    end
  endtask

  task automatic check_err(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      err_count++;
      $display("ERROR %s err expected %b actual %b", name, exp, act);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Sampling at the falling edge
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (rst_n && instr_valid && instr_ready) begin
      if (seg_left == 0 || exp_idx >= exp_addr.size()) begin
        err_count++;
        $display("Instruction at %h consumed beyond the expected stream", instr_addr);
      end else begin
        check_addr(test_name, exp_addr[exp_idx], instr_addr);
        check_instr(test_name, exp_word[exp_idx], instr);
        check_err(test_name, exp_word[exp_idx].err, instr.err);
        exp_idx++;
        seg_left--;
      end
    end
    // Accepted request, answered from the next rising edge on
    if (rst_n && fetch_valid && fetch_ready) begin
      if (fetch_addr[1:0] != 2'b00) begin
        err_count++;
        $display("Fetch address %h is not word aligned", fetch_addr);
      end
      acc_pend = 1'b1;
      acc_addr = fetch_addr;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Memory model and decode stall, driven at the rising edge
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin : mem_model
    int         lat;
    logic [7:0] idx;
    logic       b0;
    logic       b1;
    cyc++;
    if (!rst_n) begin
      fetch_ready <= 1'b0;
      resp_valid  <= 1'b0;
      instr_ready <= 1'b0;
    end else begin
      if (acc_pend) begin
        // Latency of 1 to 3 cycles
        b0  = rand_bit();
        b1  = rand_bit();
        lat = 1 + int'(b0) + int'(b1);
        pend_addr.push_back(acc_addr);
        pend_due.push_back(cyc + lat - 1);
        acc_pend = 1'b0;
      end
      if (pend_addr.size() > 0 && pend_due[0] <= cyc) begin
        idx = pend_addr[0][9:2];
        resp_valid <= 1'b1;
        resp.rdata <= mem_data[idx];
        resp.err   <= mem_err[idx];
        void'(pend_addr.pop_front());
        void'(pend_due.pop_front());
      end else begin
        resp_valid <= 1'b0;
      end
      fetch_ready <= rand_bit();
      b0 = rand_bit();
      b1 = rand_bit();
      // Decode takes nothing once the segment is done
      instr_ready <= (seg_left != 0) && (b0 || b1);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Trace reading and scenario
  //////////////////////////////////////////////////////////////////////

  task automatic read_trace();
    int          fd;
    int          r;
    string       line;
    logic [7:0]  tag;
    logic [31:0] f1;
    logic [31:0] f2;
    logic [31:0] f3;
    resp_word_t  w;
    fd = $fopen("dv/align_trace.txt", "r");
    if (fd == 0) begin
      err_count++;
      $display("Trace file dv/align_trace.txt could not be opened");
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      r = $fgets(line, fd);
      if (line.len() < 2 || line[0] == "#") begin
        continue;
      end
      r = $sscanf(line, "%c", tag);
      if (tag == "M") begin
        r = $sscanf(line, "%c %h %h %h", tag, f1, f2, f3);
        mem_data[f1[9:2]] = f2;
        mem_err[f1[9:2]]  = f3[0];
      end else if (tag == "B" || tag == "K") begin
        r = $sscanf(line, "%c %h %d", tag, f1, f2);
        op_kind.push_back(tag);
        op_addr.push_back(f1);
        op_len.push_back(int'(f2));
      end else if (tag == "E") begin
        r = $sscanf(line, "%c %h %h %h", tag, f1, f2, f3);
        w.rdata = f2;
        w.err   = f3[0];
        exp_addr.push_back(f1);
        exp_word.push_back(w);
      end
    end
    $fclose(fd);
  endtask

  // Run limit from the stream length
  initial begin : watchdog
    wait (limit > 0);
    while (cyc < limit) @(negedge clk);
    $display("Timeout after %0d cycles, %0d of %0d instructions seen", cyc, exp_idx,
             exp_addr.size());
    $display("Checked %0d of %0d instructions, %0d errors", exp_idx, exp_addr.size(),
             err_count);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin : main
    rst_n       = 1'b0;
    prefetch_en = 1'b0;
    branch      = 1'b0;
    branch_addr = '0;
    kill        = 1'b0;
    fetch_ready = 1'b0;
    resp_valid  = 1'b0;
    resp        = '0;
    instr_ready = 1'b0;
    acc_pend    = 1'b0;
    acc_addr    = '0;
    // Unmapped words carry their own index
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem_data[i] = {8'h5A ^ 8'(i), 8'hC3, 8'(i), 8'h0F ^ 8'(i)};
      mem_err[i]  = 1'b0;
    end
    read_trace();
    limit = 20 * exp_addr.size() + 200;

    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    foreach (op_kind[k]) begin
      do @(posedge clk); while (seg_left != 0);
      prefetch_en <= 1'b1;
      branch      <= 1'b1;
      branch_addr <= op_addr[k];
      kill        <= (op_kind[k] == "K");
      @(posedge clk);
      branch <= 1'b0;
      kill   <= 1'b0;
      @(negedge clk);
      test_name = $sformatf("%s_%0d_%h", (op_kind[k] == "K") ? "kill" : "branch", k,
                            op_addr[k]);
      seg_left  = op_len[k];
    end
    do @(posedge clk); while (seg_left != 0);

    // Drain with prefetch off, busy must fall and stay low
    prefetch_en <= 1'b0;
    do @(negedge clk); while (busy);
    repeat (4) @(negedge clk);
    if (busy) begin
      err_count++;
      $display("busy_o rose again after prefetch was disabled");
    end
    if (exp_idx != exp_addr.size()) begin
      err_count++;
      $display("Only %0d of %0d expected instructions came out", exp_idx, exp_addr.size());
    end

    $display("Checked %0d of %0d instructions, %0d errors", exp_idx, exp_addr.size(),
             err_count);
    if (err_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- tb.f
+incdir+include
source/align_pkg.sv
source/fetch_req_ctrl.sv
source/insn_boundary_tracker.sv
source/resp_queue.sv
source/insn_extract.sv
source/align_buffer_top.sv
dv/align_chk.sv
dv/align_tb.sv

//--- dv/align_trace.txt
# M word_addr data err | B or K target count (K = kill with branch)
# E addr instr err, compressed entries hold only the low halfword
M 00000000 00100093 0
M 00000004 00200113 0
M 00000008 00300193 0
M 0000000C 00400213 0
M 00000040 05334505 0
M 00000044 808200A5 0
M 00000048 00B50593 0
M 0000004C 45810505 0
M 00000050 06334601 0
M 00000054 869300C6 1
M 00000058 068500D6 0
M 0000005C 00E70713 0
M 00000080 0F13FFFF 0
M 00000084 0F850100 0
M 00000088 00F00F93 0
M 000000C0 47A14709 0
M 000000C4 00178793 0
B 00000000 4
E 00000000 00100093 0
E 00000004 00200113 0
E 00000008 00300193 0
E 0000000C 00400213 0
B 00000040 11
E 00000040 00004505 0
E 00000042 00A50533 0
E 00000046 00008082 0
E 00000048 00B50593 0
E 0000004C 00000505 0
E 0000004E 00004581 0
E 00000050 00004601 0
E 00000052 00C60633 1
E 00000056 00D68693 1
E 0000005A 00000685 0
E 0000005C 00E70713 0
B 00000082 3
E 00000082 01000F13 0
E 00000086 00000F85 0
E 00000088 00F00F93 0
K 000000C0 3
E 000000C0 00004709 0
E 000000C2 000047A1 0
E 000000C4 00178793 0
